// File: verification/cpu_tb.sv
`timescale 1ns/100ps

module cpu_tb;

	logic clk;
	logic reset;
	logic run;
	cpu_pkg::load_req_t load;
	cpu_pkg::out_resp_t out_resp;

	// program image built by each test before loading
	logic [cpu_pkg::data_width-1:0] prog_buf [cpu_pkg::rom_depth];
	int prog_len;

	// bookkeeping
	string test_name;
	int test_errors;
	int tests_passed;
	int tests_failed;

	// cycles allowed for any single output wait
	int out_timeout = 40;

	cpu_top cpu_top_inst (
		.clk(clk),
		.reset(reset),
		.run(run),
		.load(load),
		.out_resp(out_resp)
	);

	// 100 ns clock
	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// instruction encoders built from the ISA field layout
	function automatic logic [15:0] ldi_instr(input logic [2:0] ra, input logic [7:0] imm);
		return {cpu_pkg::op_ldi, ra, 1'b0, imm};
	endfunction

	function automatic logic [15:0] add_instr(input logic [2:0] ra, input logic [2:0] rb);
		return {cpu_pkg::op_add, ra, rb, 6'b0};
	endfunction

	function automatic logic [15:0] sub_instr(input logic [2:0] ra, input logic [2:0] rb);
		return {cpu_pkg::op_sub, ra, rb, 6'b0};
	endfunction

	function automatic logic [15:0] jmp_instr(input logic [3:0] target);
		return {cpu_pkg::op_jmp, target, 8'b0};
	endfunction

	function automatic logic [15:0] bz_instr(input logic [3:0] target);
		return {cpu_pkg::op_bz, target, 8'b0};
	endfunction

	function automatic logic [15:0] out_instr(input logic [2:0] ra);
		return {cpu_pkg::op_out, ra, 9'b0};
	endfunction

	// append one word to the program image
	function automatic void push_word(input logic [15:0] word);
		prog_buf[prog_len] = word;
		prog_len++;
	endfunction

	// stop the core and send one load strobe per word
	task automatic load_program();
		@(posedge clk);
		run <= 1'b0;
		for (int i = 0; i < prog_len; i++) begin
			load.strobe <= 1'b1;
			load.addr <= 4'(i);
			load.data <= prog_buf[i];
			@(posedge clk);
		end
		load.strobe <= 1'b0;
	endtask

	// reset held for two cycles while run stays low
	task automatic apply_reset();
		@(posedge clk);
		run <= 1'b0;
		reset <= 1'b1;
		repeat (2) @(posedge clk);
		reset <= 1'b0;
	endtask

	// run rises at the same edge that releases reset
	task automatic start_run();
		apply_reset();
		run <= 1'b1;
	endtask

	// count negedges until a strobe shows up or the limit is hit
	task automatic wait_out(output int waited, output bit seen);
		waited = 0;
		seen = 1'b0;
		while (!seen && waited < out_timeout) begin
			@(negedge clk);
			waited++;
			seen = out_resp.strobe;
		end
		assert (seen) else begin
			$display("timeout: no output strobe within %0d cycles", out_timeout);
			test_errors++;
		end
	endtask

	task automatic check_value(input string name, input logic [15:0] expected,
			input logic [15:0] actual);
		assert (actual === expected) else begin
			$display("** Error: %s expected %h, actual %h", name, expected, actual);
			test_errors++;
		end
	endtask

	// next output must carry this value
	// want_wait of zero skips the delay check
	task automatic expect_out(input logic [15:0] expected, input int want_wait);
		int waited;
		bit seen;
		wait_out(waited, seen);
		if (seen) begin
			check_value("out_resp.data", expected, out_resp.data);
			if (want_wait > 0) begin
				check_value("out_resp.strobe delay", 16'(want_wait), 16'(waited));
			end
		end
	endtask

	// no strobe allowed for a number of cycles
	task automatic check_quiet(input int cycles);
		for (int i = 0; i < cycles; i++) begin
			@(negedge clk);
			assert (!out_resp.strobe) else begin
				$display("unexpected output strobe, data %h", out_resp.data);
				test_errors++;
			end
		end
	endtask

	task automatic new_test(input string name);
		test_name = name;
		test_errors = 0;
		prog_len = 0;
	endtask

	task automatic report_test();
		if (test_errors == 0) begin
			tests_passed++;
			$display("%s: passed", test_name);
		end else begin
			tests_failed++;
			$display("%s: failed with %0d errors", test_name, test_errors);
		end
	endtask

	// all registers read back as zero after reset
	task automatic reset_state_test();
		new_test("reset state");
		for (int r = 0; r < 8; r++) begin
			push_word(out_instr(3'(r)));
		end
		push_word(jmp_instr(4'd8));
		load_program();
		apply_reset();
		// core must stay silent while run is low
		check_quiet(6);
		start_run();
		// address 0 executes at the first edge and its strobe shows one cycle on
		expect_out(16'h0000, 2);
		for (int r = 1; r < 8; r++) begin
			expect_out(16'h0000, 1);
		end
		check_quiet(8);
		report_test();
	endtask

	// ldi loads the zero-extended byte and outs come back in order
	task automatic immediate_test();
		logic [7:0] imm [4];
		imm[0] = 8'h12;
		imm[1] = 8'hA5;
		imm[2] = 8'hFF;
		imm[3] = 8'h07;
		new_test("load immediate and out");
		// registers hold a nonzero byte first
		// so an ldi that adds would show up
		for (int r = 0; r < 4; r++) begin
			push_word(ldi_instr(3'(r + 1), 8'hFF));
		end
		for (int r = 0; r < 4; r++) begin
			push_word(ldi_instr(3'(r + 1), imm[r]));
		end
		for (int r = 0; r < 4; r++) begin
			push_word(out_instr(3'(r + 1)));
		end
		push_word(jmp_instr(4'd12));
		load_program();
		start_run();
		// first out is the ninth instruction and strobes one cycle after its edge
		expect_out({8'h00, imm[0]}, 10);
		for (int r = 1; r < 4; r++) begin
			expect_out({8'h00, imm[r]}, 1);
		end
		check_quiet(8);
		report_test();
	endtask

	// add and subtract with wrap at 16 bits
	task automatic arithmetic_test();
		logic [15:0] m1;
		logic [15:0] m2;
		logic [15:0] m3;
		logic [15:0] m5;
		logic [15:0] expected [$];
		new_test("arithmetic");
		push_word(ldi_instr(3'd1, 8'hFF));
		push_word(ldi_instr(3'd2, 8'hFF));
		push_word(add_instr(3'd1, 3'd2));
		push_word(add_instr(3'd1, 3'd1));
		push_word(out_instr(3'd1));
		push_word(ldi_instr(3'd5, 8'h01));
		push_word(sub_instr(3'd3, 3'd5));
		push_word(out_instr(3'd3));
		push_word(add_instr(3'd3, 3'd1));
		push_word(out_instr(3'd3));
		push_word(sub_instr(3'd2, 3'd1));
		push_word(out_instr(3'd2));
		push_word(jmp_instr(4'd12));
		// reference model starting from cleared registers
		m1 = 16'h00FF;
		m2 = 16'h00FF;
		m3 = 16'h0000;
		m1 = m1 + m2;
		m1 = m1 + m1;
		expected.push_back(m1);
		m5 = 16'h0001;
		// zero minus one goes below zero
		m3 = m3 - m5;
		expected.push_back(m3);
		m3 = m3 + m1;
		expected.push_back(m3);
		m2 = m2 - m1;
		expected.push_back(m2);
		load_program();
		start_run();
		while (expected.size() > 0) begin
			expect_out(expected.pop_front(), 0);
		end
		check_quiet(8);
		report_test();
	endtask

	// jmp skips an out and bz follows the flag from the last sub only
	task automatic control_flow_test();
		logic [15:0] m1;
		logic [15:0] m2;
		logic [15:0] m3;
		logic zero;
		logic [15:0] expected [$];
		new_test("control flow");
		push_word(ldi_instr(3'd1, 8'h05));
		push_word(ldi_instr(3'd2, 8'h05));
		push_word(jmp_instr(4'd4));
		push_word(out_instr(3'd1));
		push_word(sub_instr(3'd1, 3'd2));
		push_word(ldi_instr(3'd3, 8'h33));
		push_word(add_instr(3'd3, 3'd3));
		push_word(bz_instr(4'd9));
		push_word(out_instr(3'd2));
		push_word(out_instr(3'd3));
		push_word(sub_instr(3'd3, 3'd2));
		push_word(bz_instr(4'd13));
		push_word(out_instr(3'd3));
		push_word(out_instr(3'd1));
		push_word(jmp_instr(4'd14));
		// model walk where the out at address 3 is jumped over
		m1 = 16'h0005;
		m2 = 16'h0005;
		m1 = m1 - m2;
		zero = (m1 == 16'h0000);
		// ldi and add leave the flag alone
		m3 = 16'h0033;
		m3 = m3 + m3;
		if (!zero) begin
			expected.push_back(m2);
		end
		expected.push_back(m3);
		m3 = m3 - m2;
		zero = (m3 == 16'h0000);
		if (!zero) begin
			expected.push_back(m3);
		end
		expected.push_back(m1);
		load_program();
		start_run();
		while (expected.size() > 0) begin
			expect_out(expected.pop_front(), 0);
		end
		check_quiet(10);
		report_test();
	endtask

	// random byte pairs through add and sub
	task automatic random_pairs_test();
		logic [7:0] a;
		logic [7:0] b;
		logic [15:0] sum;
		logic [15:0] diff;
		new_test("randomized pairs");
		for (int p = 0; p < 20; p++) begin
			a = 8'($urandom());
			b = 8'($urandom());
			prog_len = 0;
			push_word(ldi_instr(3'd1, a));
			push_word(ldi_instr(3'd2, b));
			push_word(ldi_instr(3'd3, a));
			push_word(add_instr(3'd1, 3'd2));
			push_word(out_instr(3'd1));
			push_word(sub_instr(3'd3, 3'd2));
			push_word(out_instr(3'd3));
			push_word(jmp_instr(4'd7));
			sum = {8'h00, a} + {8'h00, b};
			diff = {8'h00, a} - {8'h00, b};
			load_program();
			start_run();
			// outs at addresses 4 and 6
			expect_out(sum, 6);
			expect_out(diff, 2);
			// the closing jump to itself lets nothing more come out
			check_quiet(10);
		end
		report_test();
	endtask

	initial begin
		void'($urandom(10466));
		reset = 1'b1;
		run = 1'b0;
		load = '0;
		prog_len = 0;
		test_errors = 0;
		tests_passed = 0;
		tests_failed = 0;
		repeat (2) @(posedge clk);
		reset <= 1'b0;

		reset_state_test();
		immediate_test();
		arithmetic_test();
		control_flow_test();
		random_pairs_test();

		$display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
		if (tests_failed == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

// File: verilog.f
verilog/cpu_pkg.sv
verilog/program_rom.sv
verilog/register_file.sv
verilog/cpu_core.sv
verilog/cpu_top.sv
verification/cpu_tb.sv

// File: verilog/cpu_core.sv
`timescale 1ns/100ps

module cpu_core (
	input logic clk,
	input logic reset,
	input logic run,
	input cpu_pkg::instruction_u instruction,
	output logic [cpu_pkg::pc_width-1:0] pc,
	output logic [cpu_pkg::reg_addr_width-1:0] read_a_addr,
	output logic [cpu_pkg::reg_addr_width-1:0] read_b_addr,
	input logic [cpu_pkg::data_width-1:0] read_a_data,
	input logic [cpu_pkg::data_width-1:0] read_b_data,
	output cpu_pkg::reg_write_t reg_write,
	output cpu_pkg::out_resp_t out_resp
);

	// decoded opcode
	cpu_pkg::opcode_e opcode;

	// one-hot instruction class
	logic is_ldi;
	logic is_add;
	logic is_sub;
	logic is_jmp;
	logic is_bz;
	logic is_out;

	// zero status, written only by sub
	logic zero;

	// alu results
	logic [cpu_pkg::data_width-1:0] sum;
	logic [cpu_pkg::data_width-1:0] diff;
	logic [cpu_pkg::data_width-1:0] imm_ext;
	logic [cpu_pkg::data_width-1:0] write_data;
	logic write_enable;

	// next pc selection
	logic [cpu_pkg::pc_width-1:0] pc_inc;
	logic [cpu_pkg::pc_width-1:0] jump_target;
	logic branch_taken;
	logic [cpu_pkg::pc_width-1:0] pc_next;

	// opcode sits in the same place in every format
	assign opcode = instruction.reg_fmt.opcode;

	// register indices
	// ra is shared by register and immediate formats
	assign read_a_addr = instruction.reg_fmt.ra;
	assign read_b_addr = instruction.reg_fmt.rb;

	// jump target from the jump view of the word
	assign jump_target = instruction.jump_fmt.target;

	// instruction class decode
	// anything not listed falls through as a no-op
	always_comb begin
		is_ldi = 1'b0;
		is_add = 1'b0;
		is_sub = 1'b0;
		is_jmp = 1'b0;
		is_bz = 1'b0;
		is_out = 1'b0;
		case (opcode)
			cpu_pkg::op_ldi: begin
				is_ldi = 1'b1;
			end
			cpu_pkg::op_add: begin
				is_add = 1'b1;
			end
			cpu_pkg::op_sub: begin
				is_sub = 1'b1;
			end
			cpu_pkg::op_jmp: begin
				is_jmp = 1'b1;
			end
			cpu_pkg::op_bz: begin
				is_bz = 1'b1;
			end
			cpu_pkg::op_out: begin
				is_out = 1'b1;
			end
			default: begin
				// no-op
			end
		endcase
	end

	// add and subtract, both wrap at 16 bits
	assign sum = read_a_data + read_b_data;
	assign diff = read_a_data - read_b_data;

	// immediate is zero-extended and loaded, not added
	assign imm_ext = {
		{(cpu_pkg::data_width - cpu_pkg::imm_width){1'b0}},
		instruction.imm_fmt.imm
	};

	// write data select
	always_comb begin
		write_data = sum;
		write_enable = 1'b0;
		if (is_ldi) begin
			write_data = imm_ext;
			write_enable = 1'b1;
		end else if (is_add) begin
			write_data = sum;
			write_enable = 1'b1;
		end else if (is_sub) begin
			write_data = diff;
			write_enable = 1'b1;
		end
	end

	// register write port
	// held off while the core is stopped
	always_comb begin
		reg_write.enable = run & write_enable;
		reg_write.addr = instruction.reg_fmt.ra;
		reg_write.data = write_data;
	end

	// pc increment, wraps at 16 words
	assign pc_inc = pc + 1'b1;

	// jmp always, bz only on zero flag
	assign branch_taken = is_jmp | (is_bz & zero);

	assign pc_next = branch_taken ? jump_target : pc_inc;

	// program counter and zero flag
	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= '0;
			zero <= 1'b0;
		end else if (run) begin
			pc <= pc_next;
			// Only sub touches the flag; add and ldi leave it alone.
			if (is_sub) begin
				zero <= (diff == '0);
			end
		end
	end

	// output register
	// strobe lasts one cycle, data holds until the next out
	always_ff @(posedge clk) begin
		if (reset) begin
			out_resp <= '0;
		end else begin
			out_resp.strobe <= run & is_out;
			if (run && is_out) begin
				out_resp.data <= read_a_data;
			end
		end
	end

endmodule

// File: verilog/cpu_pkg.sv
package cpu_pkg;

	// datapath sizes
	localparam int data_width = 16;
	localparam int reg_addr_width = 3;
	localparam int pc_width = 4;
	localparam int rom_depth = 16;

	// instruction field sizes
	localparam int opcode_width = 4;
	localparam int imm_width = 8;

	// top nibble of every instruction word
	typedef enum logic [opcode_width-1:0] {
		op_ldi = 4'd1,
		op_add = 4'd2,
		op_sub = 4'd3,
		op_jmp = 4'd8,
		op_bz = 4'd12,
		op_out = 4'd15
	} opcode_e;

	// add, sub and out use ra and rb
	typedef struct packed {
		opcode_e opcode;
		logic [reg_addr_width-1:0] ra;
		logic [reg_addr_width-1:0] rb;
		logic [data_width-opcode_width-2*reg_addr_width-1:0] unused;
	} reg_format_t;

	// ldi, low byte is the immediate
	typedef struct packed {
		opcode_e opcode;
		logic [reg_addr_width-1:0] ra;
		logic unused;
		logic [imm_width-1:0] imm;
	} imm_format_t;

	// jmp and bz, target is a full program address
	typedef struct packed {
		opcode_e opcode;
		logic [pc_width-1:0] target;
		logic [data_width-opcode_width-pc_width-1:0] unused;
	} jump_format_t;

	// one 16-bit word seen three ways
	typedef union packed {
		reg_format_t reg_fmt;
		imm_format_t imm_fmt;
		jump_format_t jump_fmt;
	} instruction_u;

	// program load from outside, no handshake
	typedef struct packed {
		logic strobe;
		logic [pc_width-1:0] addr;
		logic [data_width-1:0] data;
	} load_req_t;

	// result port
	typedef struct packed {
		logic strobe;
		logic [data_width-1:0] data;
	} out_resp_t;

	// single register write port
	typedef struct packed {
		logic enable;
		logic [reg_addr_width-1:0] addr;
		logic [data_width-1:0] data;
	} reg_write_t;

endpackage

// File: verilog/cpu_top.sv
`timescale 1ns/100ps

module cpu_top (
	input logic clk,
	input logic reset,
	input logic run,
	input cpu_pkg::load_req_t load,
	output cpu_pkg::out_resp_t out_resp
);

	// fetch path
	logic [cpu_pkg::pc_width-1:0] pc;
	cpu_pkg::instruction_u instruction;

	// register file ports
	logic [cpu_pkg::reg_addr_width-1:0] read_a_addr;
	logic [cpu_pkg::reg_addr_width-1:0] read_b_addr;
	logic [cpu_pkg::data_width-1:0] read_a_data;
	logic [cpu_pkg::data_width-1:0] read_b_data;
	cpu_pkg::reg_write_t reg_write;

	// program store, loaded from outside
	program_rom program_rom_inst (
		.clk(clk),
		.load(load),
		.pc(pc),
		.instruction(instruction)
	);

	// register file
	register_file register_file_inst (
		.clk(clk),
		.reset(reset),
		.read_a_addr(read_a_addr),
		.read_b_addr(read_b_addr),
		.write(reg_write),
		.read_a_data(read_a_data),
		.read_b_data(read_b_data)
	);

	// execute core
	// one instruction per clock while run is high
	cpu_core cpu_core_inst (
		.clk(clk),
		.reset(reset),
		.run(run),
		.instruction(instruction),
		.pc(pc),
		.read_a_addr(read_a_addr),
		.read_b_addr(read_b_addr),
		.read_a_data(read_a_data),
		.read_b_data(read_b_data),
		.reg_write(reg_write),
		.out_resp(out_resp)
	);

endmodule

// File: verilog/program_rom.sv
`timescale 1ns/100ps

module program_rom (
	input logic clk,
	input cpu_pkg::load_req_t load,
	input logic [cpu_pkg::pc_width-1:0] pc,
	output cpu_pkg::instruction_u instruction
);

	// program words
	// no reset here, contents outlive a core reset
	logic [cpu_pkg::data_width-1:0] mem [cpu_pkg::rom_depth];

	// fetch data for the current pc
	logic [cpu_pkg::data_width-1:0] fetch_word;

	// load port write
	// one word per strobe, any cycle
	always_ff @(posedge clk) begin
		if (load.strobe) begin
			mem[load.addr] <= load.data;
		end
	end

	// combinational read at pc
	assign fetch_word = mem[pc];

	// hand the raw word over as the decoded union
	assign instruction = cpu_pkg::instruction_u'(fetch_word);

endmodule

// File: verilog/register_file.sv
`timescale 1ns/100ps

module register_file (
	input logic clk,
	input logic reset,
	input logic [cpu_pkg::reg_addr_width-1:0] read_a_addr,
	input logic [cpu_pkg::reg_addr_width-1:0] read_b_addr,
	input cpu_pkg::reg_write_t write,
	output logic [cpu_pkg::data_width-1:0] read_a_data,
	output logic [cpu_pkg::data_width-1:0] read_b_data
);

	localparam int reg_count = 2 ** cpu_pkg::reg_addr_width;

	// eight general registers
	logic [cpu_pkg::data_width-1:0] regs [reg_count];

	// write port
	// all registers back to zero on reset
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < reg_count; i++) begin
				regs[i] <= '0;
			end
		end else if (write.enable) begin
			regs[write.addr] <= write.data;
		end
	end

	// read ports, no bypass
	// a write lands at the edge, so the next instruction sees it
	assign read_a_data = regs[read_a_addr];
	assign read_b_data = regs[read_b_addr];

endmodule
